/* logic/rx_dma_params.svh */
`ifndef RX_DMA_PARAMS_SVH
`define RX_DMA_PARAMS_SVH

// Frame ring geometry
`define RING_DEPTH      512
`define RING_ADDR_W     9
// Address plus one wrap bit, so full and empty differ
`define RING_PTR_W      10

// Receive word
`define QWORD_W         64
`define BYTE_EN_W       8

// Largest chunk offered to the DMA engine
`define MAX_TLP_QWORDS  16
`define QCOUNT_W        5

`endif

/* logic/rx_dma_pkg.sv */
`default_nettype none
`include "rx_dma_params.svh"

package rx_dma_pkg;

    typedef logic [`RING_ADDR_W-1:0] ring_addr_t;   // Ring slot index
    typedef logic [`RING_PTR_W-1:0]  ring_ptr_t;    // Index plus wrap bit
    typedef logic [`QWORD_W-1:0]     qword_t;
    typedef logic [`BYTE_EN_W-1:0]   byte_en_t;     // One bit per valid byte

    // One ring slot, data and its byte mask side by side
    typedef struct packed {
        qword_t   data;
        byte_en_t byte_en;
    } ring_entry_t;

    typedef logic [31:0]             frame_count_t;
    typedef logic [`QCOUNT_W-1:0]    qcount_t;      // Up to 16 qwords

endpackage

`default_nettype wire

/* logic/mac_rx_writer.sv */
`timescale 1ns/1ns
`default_nettype none
`include "rx_dma_params.svh"

module mac_rx_writer (
    input  wire                           xaui_clk_156_25_out,
    input  wire                           reset_n,
    input  wire rx_dma_pkg::qword_t       rx_data,
    input  wire rx_dma_pkg::byte_en_t     rx_data_valid,
    input  wire                           rx_good_frame,
    input  wire                           rx_bad_frame,
    input  wire rx_dma_pkg::ring_ptr_t    commited_rd_address,
    output logic                          wr_en,
    output rx_dma_pkg::ring_addr_t        wr_addr,
    output rx_dma_pkg::ring_entry_t       wr_entry,
    output rx_dma_pkg::ring_ptr_t         commited_wr_address,
    output rx_dma_pkg::frame_count_t      good_frames,
    output rx_dma_pkg::frame_count_t      bad_frames,
    output rx_dma_pkg::frame_count_t      dropped_frames
);
    import rx_dma_pkg::*;

    ring_ptr_t wr_ptr;        // Working pointer, ahead of the committed one
    ring_ptr_t ring_used;
    logic      qword_in;
    logic      ring_full;
    logic      overrun;       // Current frame lost a qword to a full ring
    logic      frame_end;

    // ------------------------------------------------------------------
    // Write port, straight from the MAC
    // ------------------------------------------------------------------
    assign qword_in  = (rx_data_valid != '0);
    assign ring_used = wr_ptr - commited_rd_address;        // Includes uncommitted qwords
    assign ring_full = (ring_used == ring_ptr_t'(`RING_DEPTH));
    assign frame_end = rx_good_frame || rx_bad_frame;

    assign wr_en    = qword_in && !ring_full && !overrun;   // Overrun frame writes no more
    assign wr_addr  = wr_ptr[`RING_ADDR_W-1:0];
    assign wr_entry = '{data: rx_data, byte_en: rx_data_valid};

    // ------------------------------------------------------------------
    // Working and committed pointers
    // ------------------------------------------------------------------
    always_ff @(posedge xaui_clk_156_25_out or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr              <= '0;
            commited_wr_address <= '0;
            overrun             <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (qword_in && ring_full) begin
                overrun <= 1'b1;
            end
            if (frame_end) begin
                overrun <= 1'b0;                            // Next frame starts clean
                if (rx_good_frame && !overrun) begin
                    commited_wr_address <= wr_ptr;          // Frame now visible to reader
                end else begin
                    wr_ptr <= commited_wr_address;          // Rewind, discard partial frame
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // Frame counters
    // ------------------------------------------------------------------
    always_ff @(posedge xaui_clk_156_25_out or negedge reset_n) begin
        if (!reset_n) begin
            good_frames    <= '0;
            bad_frames     <= '0;
            dropped_frames <= '0;
        end else if (frame_end) begin
            // A frame that hit the full ring is dropped whatever its status
            if (overrun) begin
                dropped_frames <= dropped_frames + 1'b1;
            end else if (rx_good_frame) begin
                good_frames <= good_frames + 1'b1;
            end else begin
                bad_frames <= bad_frames + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------
    a_end_exclusive: assert property (@(posedge xaui_clk_156_25_out) disable iff (!reset_n)
        !(rx_good_frame && rx_bad_frame));

    // Reader never passes the committed write pointer, so no write lands on unread data
    a_no_overfill: assert property (@(posedge xaui_clk_156_25_out) disable iff (!reset_n)
        ring_used <= ring_ptr_t'(`RING_DEPTH));

endmodule

`default_nettype wire

/* logic/frame_ring_ram.sv */
`timescale 1ns/1ns
`default_nettype none
`include "rx_dma_params.svh"

module frame_ring_ram (
    input  wire                           xaui_clk_156_25_out,
    input  wire                           wr_en,
    input  wire rx_dma_pkg::ring_addr_t   wr_addr,
    input  wire rx_dma_pkg::ring_entry_t  wr_entry,
    input  wire rx_dma_pkg::ring_addr_t   rd_addr,
    output rx_dma_pkg::ring_entry_t       rd_entry
);
    import rx_dma_pkg::*;

    // ------------------------------------------------------------------
    // 512 x 72 storage, simple dual port
    // ------------------------------------------------------------------
    ring_entry_t mem [0:`RING_DEPTH-1];

    // Write port
    always_ff @(posedge xaui_clk_156_25_out) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_entry;
        end
    end

    // Read port, one cycle of latency
    always_ff @(posedge xaui_clk_156_25_out) begin
        rd_entry <= mem[rd_addr];                           // Old data on same-address write
    end

endmodule

`default_nettype wire

/* logic/tlp_trigger.sv */
`timescale 1ns/1ns
`default_nettype none
`include "rx_dma_params.svh"

module tlp_trigger (
    input  wire                           xaui_clk_156_25_out,
    input  wire                           reset_n,
    input  wire rx_dma_pkg::ring_ptr_t    commited_wr_address,
    input  wire                           trigger_tlp_ack,
    input  wire rx_dma_pkg::ring_entry_t  rd_entry,
    output logic                          trigger_tlp,
    output rx_dma_pkg::qcount_t           qwords_to_send,
    output rx_dma_pkg::ring_ptr_t         commited_rd_address,
    output rx_dma_pkg::ring_addr_t        rd_addr,
    output rx_dma_pkg::qword_t            tlp_qword,
    output rx_dma_pkg::byte_en_t          tlp_byte_en,
    output logic                          tlp_qword_valid,
    output logic                          tlp_last
);
    import rx_dma_pkg::*;

    ring_ptr_t avail;         // Committed qwords not yet sent
    qcount_t   next_chunk;
    ring_ptr_t rd_ptr;        // Walks through the current chunk
    qcount_t   chunk_len;     // Length latched on the acknowledge
    qcount_t   issue_left;
    logic      issuing;
    logic      issue_last;

    assign avail      = commited_wr_address - commited_rd_address;
    assign next_chunk = (avail > ring_ptr_t'(`MAX_TLP_QWORDS)) ?
                        qcount_t'(`MAX_TLP_QWORDS) : avail[`QCOUNT_W-1:0];
    assign issue_last = issuing && (issue_left == qcount_t'(1));

    assign rd_addr     = rd_ptr[`RING_ADDR_W-1:0];
    assign tlp_qword   = rd_entry.data;                     // Valid with tlp_qword_valid
    assign tlp_byte_en = rd_entry.byte_en;

    // ------------------------------------------------------------------
    // Chunk offer to the DMA engine
    // ------------------------------------------------------------------
    always_ff @(posedge xaui_clk_156_25_out or negedge reset_n) begin
        if (!reset_n) begin
            trigger_tlp    <= 1'b0;
            qwords_to_send <= '0;
            chunk_len      <= '0;
        end else if (trigger_tlp) begin
            if (trigger_tlp_ack) begin
                trigger_tlp <= 1'b0;
                chunk_len   <= qwords_to_send;
            end
        end else if (!issuing && (avail != '0)) begin
            trigger_tlp    <= 1'b1;
            qwords_to_send <= next_chunk;                   // Held until acknowledged
        end
    end

    // ------------------------------------------------------------------
    // Ring read sequencing
    // ------------------------------------------------------------------
    always_ff @(posedge xaui_clk_156_25_out or negedge reset_n) begin
        if (!reset_n) begin
            issuing             <= 1'b0;
            issue_left          <= '0;
            rd_ptr              <= '0;
            commited_rd_address <= '0;
        end else if (trigger_tlp && trigger_tlp_ack) begin
            issuing    <= 1'b1;
            issue_left <= qwords_to_send;
            rd_ptr     <= commited_rd_address;
        end else if (issuing) begin
            rd_ptr     <= rd_ptr + 1'b1;
            issue_left <= issue_left - 1'b1;
            if (issue_last) begin
                issuing             <= 1'b0;
                commited_rd_address <= commited_rd_address + ring_ptr_t'(chunk_len);
            end
        end
    end

    // Strobes delayed one cycle to line up with the RAM output
    always_ff @(posedge xaui_clk_156_25_out or negedge reset_n) begin
        if (!reset_n) begin
            tlp_qword_valid <= 1'b0;
            tlp_last        <= 1'b0;
        end else begin
            tlp_qword_valid <= issuing;
            tlp_last        <= issue_last;
        end
    end

    // ------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------
    a_ack_needs_trigger: assert property (@(posedge xaui_clk_156_25_out) disable iff (!reset_n)
        trigger_tlp_ack |-> trigger_tlp);

    // Offered chunk stays within the committed data
    a_chunk_len_range: assert property (@(posedge xaui_clk_156_25_out) disable iff (!reset_n)
        trigger_tlp |-> (qwords_to_send != '0) &&
                        (qwords_to_send <= qcount_t'(`MAX_TLP_QWORDS)) &&
                        (ring_ptr_t'(qwords_to_send) <= avail));

endmodule

`default_nettype wire

/* logic/rx_dma_top.sv */
`timescale 1ns/1ns
`default_nettype none

module rx_dma_top (
    input  wire                            xaui_clk_156_25_out,
    input  wire                            reset_n,
    input  wire rx_dma_pkg::qword_t        rx_data,
    input  wire rx_dma_pkg::byte_en_t      rx_data_valid,
    input  wire                            rx_good_frame,
    input  wire                            rx_bad_frame,
    input  wire                            trigger_tlp_ack,
    output wire                            trigger_tlp,
    output wire rx_dma_pkg::qcount_t       qwords_to_send,
    output wire rx_dma_pkg::qword_t        tlp_qword,
    output wire rx_dma_pkg::byte_en_t      tlp_byte_en,
    output wire                            tlp_qword_valid,
    output wire                            tlp_last,
    output wire rx_dma_pkg::frame_count_t  good_frames,
    output wire rx_dma_pkg::frame_count_t  bad_frames,
    output wire rx_dma_pkg::frame_count_t  dropped_frames
);

    // ------------------------------------------------------------------
    // Internal nets
    // ------------------------------------------------------------------
    wire                           wr_en;
    wire rx_dma_pkg::ring_addr_t   wr_addr;
    wire rx_dma_pkg::ring_entry_t  wr_entry;
    wire rx_dma_pkg::ring_addr_t   rd_addr;
    wire rx_dma_pkg::ring_entry_t  rd_entry;
    wire rx_dma_pkg::ring_ptr_t    commited_wr_address;  // Writer to reader
    wire rx_dma_pkg::ring_ptr_t    commited_rd_address;  // Reader back to writer

    mac_rx_writer u_mac_rx_writer (
        .xaui_clk_156_25_out (xaui_clk_156_25_out),
        .reset_n             (reset_n),
        .rx_data             (rx_data),
        .rx_data_valid       (rx_data_valid),
        .rx_good_frame       (rx_good_frame),
        .rx_bad_frame        (rx_bad_frame),
        .commited_rd_address (commited_rd_address),
        .wr_en               (wr_en),
        .wr_addr             (wr_addr),
        .wr_entry            (wr_entry),
        .commited_wr_address (commited_wr_address),
        .good_frames         (good_frames),
        .bad_frames          (bad_frames),
        .dropped_frames      (dropped_frames)
    );

    frame_ring_ram u_frame_ring_ram (
        .xaui_clk_156_25_out (xaui_clk_156_25_out),
        .wr_en               (wr_en),
        .wr_addr             (wr_addr),
        .wr_entry            (wr_entry),
        .rd_addr             (rd_addr),
        .rd_entry            (rd_entry)
    );

    tlp_trigger u_tlp_trigger (
        .xaui_clk_156_25_out (xaui_clk_156_25_out),
        .reset_n             (reset_n),
        .commited_wr_address (commited_wr_address),
        .trigger_tlp_ack     (trigger_tlp_ack),
        .rd_entry            (rd_entry),
        .trigger_tlp         (trigger_tlp),
        .qwords_to_send      (qwords_to_send),
        .commited_rd_address (commited_rd_address),
        .rd_addr             (rd_addr),
        .tlp_qword           (tlp_qword),
        .tlp_byte_en         (tlp_byte_en),
        .tlp_qword_valid     (tlp_qword_valid),
        .tlp_last            (tlp_last)
    );

endmodule

`default_nettype wire

/* tb/tb_rx_dma.sv */
`timescale 1ns/1ns
`default_nettype none
`include "rx_dma_params.svh"

module tb_rx_dma;
    import rx_dma_pkg::*;

    logic         xaui_clk_156_25_out;
    logic         reset_n;
    qword_t       rx_data;
    byte_en_t     rx_data_valid;
    logic         rx_good_frame;
    logic         rx_bad_frame;
    logic         trigger_tlp_ack;
    logic         trigger_tlp;
    qcount_t      qwords_to_send;
    qword_t       tlp_qword;
    byte_en_t     tlp_byte_en;
    logic         tlp_qword_valid;
    logic         tlp_last;
    frame_count_t good_frames;
    frame_count_t bad_frames;
    frame_count_t dropped_frames;

    logic [71:0]  model_q[$];            // Committed qwords, data over mask
    int unsigned  chunk_pops;            // Popped but not yet committed by the reader
    bit           in_chunk;
    int unsigned  since_ack;
    int unsigned  chunk_len;
    bit           ack_random;            // Low holds the acknowledge back
    integer       seed;
    int unsigned  limit_cycles;
    int unsigned  checked;
    int unsigned  mismatch_count;
    int unsigned  failure_count;

    rx_dma_top DUT (
        .xaui_clk_156_25_out (xaui_clk_156_25_out),
        .reset_n             (reset_n),
        .rx_data             (rx_data),
        .rx_data_valid       (rx_data_valid),
        .rx_good_frame       (rx_good_frame),
        .rx_bad_frame        (rx_bad_frame),
        .trigger_tlp_ack     (trigger_tlp_ack),
        .trigger_tlp         (trigger_tlp),
        .qwords_to_send      (qwords_to_send),
        .tlp_qword           (tlp_qword),
        .tlp_byte_en         (tlp_byte_en),
        .tlp_qword_valid     (tlp_qword_valid),
        .tlp_last            (tlp_last),
        .good_frames         (good_frames),
        .bad_frames          (bad_frames),
        .dropped_frames      (dropped_frames)
    );

    initial begin
        xaui_clk_156_25_out = 1'b0;
        forever #5 xaui_clk_156_25_out = ~xaui_clk_156_25_out;
    end

    task automatic report_mismatch(input string msg);
        mismatch_count++;
        $display("Mismatch at %0t: %s", $time, msg);
    endtask

    task automatic report_failure(input string msg);
        failure_count++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    // ------------------------------------------------------------------
    // MAC side stimulus
    // ------------------------------------------------------------------
    task automatic send_frame(input int unsigned len, input byte_en_t mask, input bit good,
                              input qword_t base);
        int unsigned i;
        bit          fits;
        fits = (model_q.size() + chunk_pops + len) <= `RING_DEPTH;   // Overrun frames are lost
        for (i = 0; i < len; i++) begin
            @(posedge xaui_clk_156_25_out);
            rx_data       <= base + 64'(i);
            rx_data_valid <= (i == len - 1) ? mask : 8'hff;
        end
        @(posedge xaui_clk_156_25_out);
        rx_data_valid <= '0;
        rx_good_frame <= good;
        rx_bad_frame  <= !good;
        @(posedge xaui_clk_156_25_out);
        rx_good_frame <= 1'b0;
        rx_bad_frame  <= 1'b0;
        if (good && fits) begin
            for (i = 0; i < len; i++) begin
                model_q.push_back({base + 64'(i), (i == len - 1) ? mask : 8'hff});
            end
        end
    endtask

    task automatic check_counters(input int unsigned good, input int unsigned bad,
                                  input int unsigned dropped);
        @(negedge xaui_clk_156_25_out);
        if (good_frames !== good)
            report_mismatch($sformatf("good_frames %0d, expected %0d", good_frames, good));
        if (bad_frames !== bad)
            report_mismatch($sformatf("bad_frames %0d, expected %0d", bad_frames, bad));
        if (dropped_frames !== dropped)
            report_mismatch($sformatf("dropped_frames %0d, expected %0d", dropped_frames, dropped));
    endtask

    task automatic drain_output();
        @(negedge xaui_clk_156_25_out);
        while (model_q.size() != 0 || in_chunk) @(negedge xaui_clk_156_25_out);
    endtask

    // DMA engine model, random acknowledge delay
    initial begin : ack_driver
        int unsigned delay;
        @(posedge reset_n);
        forever begin
            @(negedge xaui_clk_156_25_out);
            if (ack_random && trigger_tlp) begin
                delay = $unsigned($random(seed)) % 4;
                repeat (delay) @(negedge xaui_clk_156_25_out);
                if (ack_random) begin                       // Trigger holds until acknowledged
                    @(posedge xaui_clk_156_25_out);
                    trigger_tlp_ack <= 1'b1;
                    @(posedge xaui_clk_156_25_out);
                    trigger_tlp_ack <= 1'b0;
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // Output checker, sampled mid-cycle
    // ------------------------------------------------------------------
    initial begin : output_checker
        logic [71:0] exp;
        int unsigned size_before;        // Unread committed qwords at the previous sample
        int unsigned exp_len;
        int unsigned held_len;
        bit          trig_seen;
        @(posedge reset_n);
        forever begin
            @(negedge xaui_clk_156_25_out);
            if (trigger_tlp && (qwords_to_send == 0 || qwords_to_send > `MAX_TLP_QWORDS))
                report_mismatch($sformatf("qwords_to_send %0d out of range", qwords_to_send));
            if (trigger_tlp) begin
                // Chunk size fixed by the data committed when the trigger rose
                if (trig_seen)
                    exp_len = held_len;
                else
                    exp_len = (size_before > `MAX_TLP_QWORDS) ? `MAX_TLP_QWORDS : size_before;
                if (qwords_to_send !== exp_len)
                    report_mismatch($sformatf("qwords_to_send %0d, expected %0d",
                                              qwords_to_send, exp_len));
                held_len = exp_len;
            end
            if (in_chunk) begin
                since_ack++;                                // Data starts two cycles after ack
                if (tlp_qword_valid !== (since_ack >= 2 && since_ack <= chunk_len + 1))
                    report_mismatch($sformatf("tlp_qword_valid %b, %0d cycles after ack",
                                              tlp_qword_valid, since_ack));
                if (tlp_last !== (since_ack == chunk_len + 1))
                    report_mismatch($sformatf("tlp_last %b, %0d cycles after ack",
                                              tlp_last, since_ack));
                if (since_ack == chunk_len + 1)
                    in_chunk = 1'b0;
            end else if (tlp_qword_valid || tlp_last) begin
                report_failure("output strobe outside an acknowledged chunk");
            end
            if (tlp_qword_valid) begin
                if (model_q.size() == 0) begin
                    report_failure($sformatf("unexpected qword %h on the output", tlp_qword));
                end else begin
                    exp = model_q.pop_front();
                    checked++;
                    chunk_pops = tlp_last ? 0 : chunk_pops + 1;
                    if (tlp_qword !== exp[71:8] || tlp_byte_en !== exp[7:0])
                        report_mismatch($sformatf("qword %h mask %h, expected %h mask %h",
                                                  tlp_qword, tlp_byte_en, exp[71:8], exp[7:0]));
                end
            end
            if (trigger_tlp_ack) begin
                if (!trigger_tlp)
                    report_failure("acknowledge driven while the trigger is low");
                in_chunk  = 1'b1;
                since_ack = 0;
                chunk_len = qwords_to_send;
            end
            trig_seen   = trigger_tlp;
            size_before = model_q.size();
        end
    end

    initial begin : watchdog
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge xaui_clk_156_25_out);
        $display("Timeout: run did not finish within %0d cycles", limit_cycles);
        $display("SIMULATION FAILED");
        $finish;
    end

    // ------------------------------------------------------------------
    // Command file and sequencing
    // ------------------------------------------------------------------
    initial begin : main
        int          fd;
        int          r;
        int          i;
        string       tok;
        string       line;
        int unsigned a0;
        int unsigned a1;
        int unsigned a2;
        qword_t      a3;
        int unsigned total_qwords;
        string       cmd_op[$];
        int unsigned cmd_a[$];
        int unsigned cmd_b[$];
        int unsigned cmd_c[$];
        qword_t      cmd_base[$];
        reset_n         = 1'b0;
        rx_data         = '0;
        rx_data_valid   = '0;
        rx_good_frame   = 1'b0;
        rx_bad_frame    = 1'b0;
        trigger_tlp_ack = 1'b0;
        ack_random      = 1'b0;
        seed            = 32'h73f05029;
        total_qwords    = 0;
        fd = $fopen("tb/rx_dma_input.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open tb/rx_dma_input.txt");
        end else begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                a0 = 0;
                a1 = 0;
                a2 = 0;
                a3 = '0;
                r  = 0;
                if (tok == "#")
                    r = $fgets(line, fd);                   // Rest of a comment line
                else if (tok == "F")
                    r = $fscanf(fd, "%d %h %d %h", a0, a1, a2, a3);
                else if (tok == "A")
                    r = $fscanf(fd, "%d", a0);
                else if (tok == "C")
                    r = $fscanf(fd, "%d %d %d", a0, a1, a2);
                else if (tok != "D")
                    report_failure($sformatf("unknown command %s in the stimulus file", tok));
                if ((tok == "F" && r != 4) || (tok == "A" && r != 1) || (tok == "C" && r != 3))
                    report_failure($sformatf("malformed %s command in the stimulus file", tok));
                if (tok != "#") begin
                    cmd_op.push_back(tok);
                    cmd_a.push_back(a0);
                    cmd_b.push_back(a1);
                    cmd_c.push_back(a2);
                    cmd_base.push_back(a3);
                end
                if (tok == "F")
                    total_qwords += a0;
            end
            $fclose(fd);
        end
        limit_cycles = total_qwords * 8 + cmd_op.size() * 50 + 2000;

        repeat (4) @(posedge xaui_clk_156_25_out);
        reset_n <= 1'b1;
        @(negedge xaui_clk_156_25_out);
        if (trigger_tlp !== 1'b0 || tlp_qword_valid !== 1'b0)
            report_mismatch("trigger_tlp or tlp_qword_valid not low after reset");
        if (good_frames !== 0 || bad_frames !== 0 || dropped_frames !== 0)
            report_mismatch("frame counters not zero after reset");

        for (i = 0; i < cmd_op.size(); i++) begin
            if (cmd_op[i] == "F")
                send_frame(cmd_a[i], byte_en_t'(cmd_b[i]), cmd_c[i] != 0, cmd_base[i]);
            else if (cmd_op[i] == "A")
                ack_random = (cmd_a[i] != 0);
            else if (cmd_op[i] == "C")
                check_counters(cmd_a[i], cmd_b[i], cmd_c[i]);
            else
                drain_output();
        end
        drain_output();
        repeat (4) @(negedge xaui_clk_156_25_out);
        if (trigger_tlp)
            report_failure("trigger still high after all expected data left the ring");

        $display("Checked %0d qwords, %0d mismatches, %0d other errors",
                 checked, mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0 && checked != 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/rx_dma_input.txt */
# F qwords last_mask(hex) good(1)/bad(0) base(hex), data = base + index
# A 1 random acknowledge, A 0 hold it | C good bad dropped | D wait for drain
A 1
F 1 01 1 0000000000001000
F 3 ff 1 0000000000002000
F 20 0f 1 0000000000003000
F 5 3f 0 badbad0000000000
F 7 7f 1 0000000000004000
F 33 03 1 0000000000005000
F 2 ff 0 badbad0000000100
F 16 ff 1 0000000000006000
D
C 6 2 0
# Acknowledge held, eight frames fill the ring and the ninth is dropped
A 0
F 64 ff 1 0000000000010000
F 64 ff 1 0000000000011000
F 64 ff 1 0000000000012000
F 64 ff 1 0000000000013000
F 64 ff 1 0000000000014000
F 64 ff 1 0000000000015000
F 64 ff 1 0000000000016000
F 64 ff 1 0000000000017000
F 10 ff 1 0000000000018000
C 14 2 1
A 1
D
F 9 1f 1 0000000000020000
F 4 0f 0 badbad0000000200
F 40 07 1 0000000000021000
D
C 16 3 1

/* build.f */
+incdir+logic
logic/rx_dma_pkg.sv
logic/mac_rx_writer.sv
logic/frame_ring_ram.sv
logic/tlp_trigger.sv
logic/rx_dma_top.sv
tb/tb_rx_dma.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then scan the log for failure
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_rx_dma \
    -f build.f -o sim_rx_dma &&
./obj_dir/sim_rx_dma > sim.log 2>&1 ; cat sim.log &&
! grep -q "SIMULATION FAILED" sim.log &&
grep -q "Checked" sim.log &&
echo "run_sim: simulation finished without errors" ||
{ echo "run_sim: build or simulation failed"; exit 1; }
